/* filelist.f */
logic/mem_map_pkg.sv
logic/address_handler.sv
logic/pointer_regs.sv
logic/access_sequencer.sv
logic/wait_timer.sv
logic/data_ram.sv
logic/mem_access_top.sv
dv/mem_access_checker.sv
dv/mem_access_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mem_access_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/mem_access_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module mem_access_tb;
    import mem_map_pkg::*;

    localparam word_t SEED            = 32'd4812;
    localparam int    DONE_TIMEOUT    = 40;  // Cycles allowed per access
    localparam int    STACK_WORDS     = 2048;
    localparam int    DATA_AREA_WORDS = 2 ** ADDR_WIDTH - DATA_AREA_BASE;

    logic    clk;
    logic    rst_n;
    logic    cmd;
    mem_op_e op;
    addr_t   addr;
    word_t   wdata;
    logic    priv;
    logic    busy;
    logic    done;
    word_t   rdata;
    logic    stack_fault;
    word_t   pc;
    word_t   sp;
    int      check_count;
    int      error_count;
    int      tb_error_count;
    int      errors_before;
    word_t   rng_state;
    addr_t   addr_list [16];

    initial clk = 1'b0;
    always #4 clk = ~clk;

    mem_access_top mem_access_top_i (.*);

    mem_access_checker mem_access_checker_i (.*);

    // xorshift32 step
    function automatic word_t random_word();
        word_t x;
        x         = rng_state;
        x         = x ^ (x << 13);
        x         = x ^ (x >> 17);
        x         = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic run_access(input mem_op_e access_op, input addr_t access_addr,
                              input word_t access_data, input logic access_priv,
                              input logic poke_busy);
        int waited;
        @(posedge clk);
        #1;
        cmd   = 1'b1;
        op    = access_op;
        addr  = access_addr;
        wdata = access_data;
        priv  = access_priv;
        @(posedge clk);
        #1;
        cmd = 1'b0;
        if (poke_busy) begin
            cmd  = 1'b1;  // Lands while busy
            op   = OP_STORE;
            addr = addr_t'(DATA_AREA_BASE);
            @(posedge clk);
            #1;
            cmd = 1'b0;
        end
        waited = 0;
        while (!done && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!done) begin
            tb_error_count++;
            $display("Timeout at %0t: no done for %s", $time, access_op.name());
        end
    endtask

    task automatic expect_quiet(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(posedge clk);
            #1;
            if (done) begin
                tb_error_count++;
                $display("Error at %0t: done after an ignored command", $time);
            end
        end
    endtask

    task automatic report_test(input string name);
        int failures;
        repeat (2) @(posedge clk);  // Let the checker see the last done
        #1;
        failures = error_count + tb_error_count - errors_before;
        if (failures == 0) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, failures);
        end
        errors_before = error_count + tb_error_count;
    endtask

    initial begin
        int i;
        rng_state      = SEED;
        rst_n          = 1'b0;
        cmd            = 1'b0;
        op             = OP_FETCH;
        addr           = '0;
        wdata          = '0;
        priv           = 1'b0;
        tb_error_count = 0;
        errors_before  = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (i = 0; i < 16; i++) begin
            addr_list[i] = addr_t'(word_t'(DATA_AREA_BASE) +
                                   random_word() % word_t'(DATA_AREA_WORDS));
            run_access(OP_STORE, addr_list[i], random_word(), 1'b0, 1'b0);
        end
        for (i = 0; i < 16; i++) begin
            run_access(OP_LOAD, addr_list[i], '0, 1'b0, 1'b0);
        end
        report_test("1 data store and load");

        for (i = 0; i < 16; i++) begin
            run_access(OP_STORE, addr_t'(i), random_word(), 1'b0, 1'b0);
        end
        for (i = 0; i < 16; i++) begin
            run_access(OP_FETCH, '0, '0, 1'b0, 1'b0);
        end
        report_test("2 code fetch");

        for (i = 0; i < 12; i++) begin
            run_access(OP_PUSH, '0, random_word(), 1'b0, 1'b0);
        end
        for (i = 0; i < 12; i++) begin
            run_access(OP_POP, '0, '0, 1'b0, 1'b0);
        end
        report_test("3 user stack order");

        for (i = 0; i < 5; i++) begin
            run_access(OP_PUSH, '0, random_word(), 1'b1, 1'b0);
        end
        for (i = 0; i < 5; i++) begin
            run_access(OP_PUSH, '0, random_word(), 1'b0, 1'b0);
        end
        for (i = 0; i < 5; i++) begin
            run_access(OP_POP, '0, '0, 1'b1, 1'b0);
        end
        for (i = 0; i < 5; i++) begin
            run_access(OP_POP, '0, '0, 1'b0, 1'b0);
        end
        report_test("4 bank independence");

        run_access(OP_POP, '0, '0, 1'b1, 1'b0);  // Empty bank
        for (i = 0; i < STACK_WORDS; i++) begin
            run_access(OP_PUSH, '0, random_word(), 1'b1, 1'b0);
        end
        run_access(OP_PUSH, '0, random_word(), 1'b1, 1'b0);
        run_access(OP_POP, '0, '0, 1'b1, 1'b0);
        report_test("5 stack faults");

        run_access(OP_STORE, addr_list[0], random_word(), 1'b0, 1'b1);
        expect_quiet(8);
        run_access(OP_LOAD, addr_list[0], '0, 1'b0, 1'b1);
        expect_quiet(8);
        report_test("6 latency and busy");

        $display("Checks %0d, errors %0d, testbench errors %0d",
                 check_count, error_count, tb_error_count);
        if (error_count == 0 && tb_error_count == 0 && check_count > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/mem_access_checker.sv */
`default_nettype none
`timescale 1ns/100ps

module mem_access_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd,
    input  mem_map_pkg::mem_op_e op,
    input  mem_map_pkg::addr_t   addr,
    input  mem_map_pkg::word_t   wdata,
    input  logic                 priv,
    input  logic                 busy,
    input  logic                 done,
    input  mem_map_pkg::word_t   rdata,
    input  logic                 stack_fault,
    input  mem_map_pkg::word_t   pc,
    input  mem_map_pkg::word_t   sp,
    output int                   check_count,
    output int                   error_count
);
    import mem_map_pkg::*;

    // done is high in the cycle after edge N + MEM_WAIT_CYCLES + 2, seen one edge later
    localparam int DONE_SLOT = MEM_WAIT_CYCLES + 3;

    word_t model_mem [2 ** ADDR_WIDTH];
    word_t model_pc;
    word_t model_priv_sp;
    word_t model_user_sp;
    word_t exp_rdata;
    word_t exp_pc;
    word_t exp_sp;
    logic  exp_fault;
    logic  exp_has_rdata;
    logic  pending;
    logic  model_busy;
    int    cycle;
    int    accept_cycle;

    // Reference model of one accepted command
    function automatic void predict(input mem_op_e req_op, input addr_t req_addr,
                                    input word_t req_data, input logic req_priv);
        word_t top;
        word_t bottom;
        word_t cur;
        top           = req_priv ? PRIV_STACK_TOP : USER_STACK_TOP;
        bottom        = req_priv ? PRIV_STACK_BOTTOM : USER_STACK_BOTTOM;
        cur           = req_priv ? model_priv_sp : model_user_sp;
        exp_fault     = 1'b0;
        exp_has_rdata = 1'b0;
        exp_rdata     = '0;
        case (req_op)
            OP_FETCH: begin
                exp_rdata     = model_mem[model_pc[ADDR_WIDTH-1:0]];
                exp_has_rdata = 1'b1;
                model_pc      = model_pc + word_t'(1);
            end
            OP_LOAD: begin
                exp_rdata     = model_mem[req_addr];
                exp_has_rdata = 1'b1;
            end
            OP_STORE: begin
                model_mem[req_addr] = req_data;
            end
            OP_PUSH: begin
                if (cur == SP_EMPTY) begin
                    cur = bottom;
                end else if (cur > top) begin
                    cur = cur - word_t'(1);
                end else begin
                    exp_fault = 1'b1;  // Full bank, memory untouched
                end
                if (!exp_fault) begin
                    model_mem[cur[ADDR_WIDTH-1:0]] = req_data;
                end
            end
            OP_POP: begin
                if (cur == SP_EMPTY) begin
                    exp_fault = 1'b1;
                end else begin
                    exp_rdata     = model_mem[cur[ADDR_WIDTH-1:0]];
                    exp_has_rdata = 1'b1;
                    cur           = (cur == bottom) ? SP_EMPTY : cur + word_t'(1);
                end
            end
            default: begin
            end
        endcase
        if (req_priv) begin
            model_priv_sp = cur;
        end else begin
            model_user_sp = cur;
        end
        exp_pc = model_pc;
        exp_sp = cur;  // sp shows the bank of the command
    endfunction

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (!rst_n) begin
            model_pc      = '0;
            model_priv_sp = SP_EMPTY;
            model_user_sp = SP_EMPTY;
            pending       = 1'b0;
            check_count   = 0;
            error_count   = 0;
        end else begin
            // Busy from the edge after acceptance up to and including done
            model_busy = pending;
            compare_word("busy", word_t'(model_busy), word_t'(busy));
            if (done) begin
                if (!pending) begin
                    error_count++;
                    $display("Error at %0t: done arrived with no accepted command", $time);
                end else begin
                    pending = 1'b0;
                    if (cycle - accept_cycle != DONE_SLOT) begin
                        error_count++;
                        $display("Error at %0t: done came %0d edges after acceptance, not %0d",
                                 $time, cycle - accept_cycle, DONE_SLOT);
                    end
                    if (exp_has_rdata) begin
                        compare_word("rdata", exp_rdata, rdata);
                    end
                    compare_word("stack_fault", word_t'(exp_fault), word_t'(stack_fault));
                    compare_word("pc", exp_pc, pc);
                    compare_word("sp", exp_sp, sp);
                end
            end else if (pending && cycle - accept_cycle > DONE_SLOT) begin
                error_count++;
                pending = 1'b0;
                $display("Error at %0t: done never arrived for an accepted command", $time);
            end
            // Accepted only while idle
            if (cmd && !model_busy) begin
                predict(op, addr, wdata, priv);
                pending      = 1'b1;
                accept_cycle = cycle;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mem_access_top.sv */
`default_nettype none
`timescale 1ns/100ps

module mem_access_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd,
    input  mem_map_pkg::mem_op_e op,
    input  mem_map_pkg::addr_t   addr,
    input  mem_map_pkg::word_t   wdata,
    input  logic                 priv,
    output logic                 busy,
    output logic                 done,
    output mem_map_pkg::word_t   rdata,
    output logic                 stack_fault,
    output mem_map_pkg::word_t   pc,
    output mem_map_pkg::word_t   sp
);
    import mem_map_pkg::*;

    logic    timer_load;
    logic    timer_zero;
    logic    capture;
    logic    commit;
    logic    ram_we;
    logic    handler_fault;
    logic    fault_q;
    logic    priv_q;
    mem_op_e op_q;
    addr_t   addr_q;
    word_t   wdata_q;
    addr_t   mem_addr;
    word_t   next_pc;
    word_t   next_sp;
    word_t   cur_pc;
    word_t   cur_sp;

    // Command capture on acceptance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_q   <= OP_FETCH;
            priv_q <= 1'b0;
        end else if (capture) begin
            op_q   <= op;
            priv_q <= priv;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    // Fault result is held for done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fault_q <= 1'b0;
        end else if (commit) begin
            fault_q <= handler_fault;
        end
    end

    // Refused pushes leave memory alone
    assign ram_we = commit && (op_q == OP_STORE || (op_q == OP_PUSH && !handler_fault));

    access_sequencer access_sequencer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .timer_zero (timer_zero),
        .busy       (busy),
        .timer_load (timer_load),
        .capture    (capture),
        .commit     (commit),
        .done       (done)
    );

    wait_timer wait_timer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (timer_load),
        .zero  (timer_zero)
    );

    address_handler address_handler_i (
        .op          (op_q),
        .addr        (addr_q),
        .cur_pc      (cur_pc),
        .cur_sp      (cur_sp),
        .priv        (priv_q),
        .mem_addr    (mem_addr),
        .next_pc     (next_pc),
        .next_sp     (next_sp),
        .stack_fault (handler_fault)
    );

    pointer_regs pointer_regs_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .commit  (commit),
        .priv    (priv_q),
        .next_pc (next_pc),
        .next_sp (next_sp),
        .cur_pc  (cur_pc),
        .cur_sp  (cur_sp)
    );

    data_ram data_ram_i (
        .clk   (clk),
        .we    (ram_we),
        .addr  (mem_addr),
        .wdata (wdata_q),
        .rdata (rdata)
    );

    assign stack_fault = fault_q;
    assign pc          = cur_pc;
    assign sp          = cur_sp;  // Bank of the last accepted command

endmodule

`default_nettype wire

/* logic/data_ram.sv */
`default_nettype none
`timescale 1ns/100ps

module data_ram (
    input  logic               clk,
    input  logic               we,
    input  mem_map_pkg::addr_t addr,
    input  mem_map_pkg::word_t wdata,
    output mem_map_pkg::word_t rdata
);
    import mem_map_pkg::*;

    localparam int RAM_DEPTH = 2 ** ADDR_WIDTH;  // Code, both stacks and data

    word_t mem [RAM_DEPTH];

    // Single port, read returns the old word on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* logic/wait_timer.sv */
`default_nettype none
`timescale 1ns/100ps

module wait_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    output logic zero
);
    import mem_map_pkg::*;

    logic [WAIT_CNT_WIDTH-1:0] count_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (load) begin
            count_q <= WAIT_CNT_WIDTH'(MEM_WAIT_CYCLES);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;  // Holds once at zero
        end
    end

    assign zero = (count_q == '0);

    // Without a reload the count stays at zero
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        (count_q == '0 && !load) |=> count_q == '0)
        else $error("Wait timer wrapped below zero");

endmodule

`default_nettype wire

/* logic/access_sequencer.sv */
`default_nettype none
`timescale 1ns/100ps

module access_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic cmd,
    input  logic timer_zero,
    output logic busy,
    output logic timer_load,
    output logic capture,
    output logic commit,
    output logic done
);
    import mem_map_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    logic       accept;

    // A command is taken only while idle
    assign accept = (state_q == ST_IDLE) && cmd;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cmd) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (timer_zero) begin
                    state_d = ST_COMMIT;  // Memory wait is over
                end
            end
            ST_COMMIT: begin
                state_d = ST_DONE;
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign busy       = (state_q != ST_IDLE);
    assign capture    = accept;  // Latch op, addr, wdata and priv
    assign timer_load = accept;  // Start the wait with the command
    assign commit     = (state_q == ST_COMMIT);
    assign done       = (state_q == ST_DONE);

    // Done never lasts more than one cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held longer than one cycle");

    // Commit only once the memory wait has run out
    a_commit_order: assert property (@(posedge clk) disable iff (!rst_n)
        commit |-> timer_zero)
        else $error("commit before the wait timer expired");

    // The full access takes the fixed latency, done is sampled one edge after it rises
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> ##(MEM_WAIT_CYCLES + 3) done)
        else $error("done missed its slot after acceptance");

endmodule

`default_nettype wire

/* logic/pointer_regs.sv */
`default_nettype none
`timescale 1ns/100ps

module pointer_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               commit,
    input  logic               priv,
    input  mem_map_pkg::word_t next_pc,
    input  mem_map_pkg::word_t next_sp,
    output mem_map_pkg::word_t cur_pc,
    output mem_map_pkg::word_t cur_sp
);
    import mem_map_pkg::*;

    word_t pc_q;
    word_t priv_sp_q;
    word_t user_sp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q      <= '0;
            priv_sp_q <= SP_EMPTY;  // Both stacks start empty
            user_sp_q <= SP_EMPTY;
        end else if (commit) begin
            pc_q <= next_pc;
            if (priv) begin
                priv_sp_q <= next_sp;
            end else begin
                user_sp_q <= next_sp;
            end
        end
    end

    assign cur_pc = pc_q;
    assign cur_sp = priv ? priv_sp_q : user_sp_q;  // Active bank only

    // Each bank stays empty or inside its own region
    a_priv_sp_range: assert property (@(posedge clk) disable iff (!rst_n)
        priv_sp_q == SP_EMPTY ||
        (priv_sp_q >= PRIV_STACK_TOP && priv_sp_q <= PRIV_STACK_BOTTOM))
        else $error("Privileged SP out of region: %0h", priv_sp_q);

    a_user_sp_range: assert property (@(posedge clk) disable iff (!rst_n)
        user_sp_q == SP_EMPTY ||
        (user_sp_q >= USER_STACK_TOP && user_sp_q <= USER_STACK_BOTTOM))
        else $error("User SP out of region: %0h", user_sp_q);

endmodule

`default_nettype wire

/* logic/address_handler.sv */
`default_nettype none
`timescale 1ns/100ps

module address_handler (
    input  mem_map_pkg::mem_op_e op,
    input  mem_map_pkg::addr_t   addr,
    input  mem_map_pkg::word_t   cur_pc,
    input  mem_map_pkg::word_t   cur_sp,
    input  logic                 priv,
    output mem_map_pkg::addr_t   mem_addr,
    output mem_map_pkg::word_t   next_pc,
    output mem_map_pkg::word_t   next_sp,
    output logic                 stack_fault
);
    import mem_map_pkg::*;

    word_t bank_top;
    word_t bank_bottom;
    word_t sp_dec;
    word_t sp_inc;
    logic  sp_empty;

    // Bank limits follow the privilege level
    assign bank_top    = priv ? PRIV_STACK_TOP : USER_STACK_TOP;
    assign bank_bottom = priv ? PRIV_STACK_BOTTOM : USER_STACK_BOTTOM;

    assign sp_empty = (cur_sp == SP_EMPTY);
    assign sp_dec   = cur_sp - word_t'(1);  // Stack grows toward the top
    assign sp_inc   = cur_sp + word_t'(1);

    // PC only moves on fetch
    assign next_pc = (op == OP_FETCH) ? cur_pc + word_t'(1) : cur_pc;

    always_comb begin
        mem_addr    = addr;
        next_sp     = cur_sp;
        stack_fault = 1'b0;
        case (op)
            OP_FETCH: begin
                mem_addr = cur_pc[ADDR_WIDTH-1:0];
            end
            OP_LOAD, OP_STORE: begin
                mem_addr = addr;  // Plain data access
            end
            OP_PUSH: begin
                if (sp_empty) begin
                    next_sp  = bank_bottom;  // First entry sits at the bottom
                    mem_addr = bank_bottom[ADDR_WIDTH-1:0];
                end else if (cur_sp > bank_top) begin
                    next_sp  = sp_dec;
                    mem_addr = sp_dec[ADDR_WIDTH-1:0];
                end else begin
                    stack_fault = 1'b1;  // Bank full
                    mem_addr    = cur_sp[ADDR_WIDTH-1:0];
                end
            end
            OP_POP: begin
                mem_addr = cur_sp[ADDR_WIDTH-1:0];
                if (sp_empty) begin
                    stack_fault = 1'b1;  // Nothing to pop
                end else if (cur_sp == bank_bottom) begin
                    next_sp = SP_EMPTY;  // Last entry leaves
                end else begin
                    next_sp = sp_inc;
                end
            end
            default: begin
                mem_addr = addr;
            end
        endcase
    end

    // A legal stack access stays in the bank chosen by priv
    always_comb begin
        if ((op == OP_PUSH || op == OP_POP) && !stack_fault) begin
            a_stack_in_bank: assert final (word_t'(mem_addr) >= bank_top &&
                                           word_t'(mem_addr) <= bank_bottom)
                else $error("Stack access at %0d outside bank %0d..%0d",
                            mem_addr, bank_top, bank_bottom);
        end
    end

endmodule

`default_nettype wire

/* logic/mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

    localparam int ADDR_WIDTH = 14;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;  // Word address into the RAM
    typedef logic [DATA_WIDTH-1:0] word_t;  // Data word and pointer value

    // Memory map in words
    localparam int    CODE_AREA_SIZE    = 4096;
    localparam word_t PRIV_STACK_TOP    = word_t'(CODE_AREA_SIZE);
    localparam word_t PRIV_STACK_BOTTOM = word_t'(6143);
    localparam word_t USER_STACK_TOP    = PRIV_STACK_BOTTOM + word_t'(1);
    localparam int    DATA_AREA_BASE    = 8192;  // Data area runs to the end of RAM
    localparam word_t USER_STACK_BOTTOM = word_t'(DATA_AREA_BASE - 1);

    localparam word_t SP_EMPTY = '1;  // Marks an empty stack

    // Memory wait before an access commits
    localparam int MEM_WAIT_CYCLES = 2;
    localparam int WAIT_CNT_WIDTH  = $clog2(MEM_WAIT_CYCLES + 1);

    typedef enum logic [2:0] {
        OP_FETCH = 3'd0,
        OP_LOAD  = 3'd1,
        OP_STORE = 3'd2,
        OP_PUSH  = 3'd3,
        OP_POP   = 3'd4
    } mem_op_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_WAIT   = 2'd1,
        ST_COMMIT = 2'd2,
        ST_DONE   = 2'd3
    } seq_state_e;

endpackage

`default_nettype wire
